// ==== Bender.yml ====
package:
  name: alu

export_include_dirs:
  - .

sources:
  - aluPkg.sv
  - aluIssue.sv
  - aluSimpleExec.sv
  - aluIntDivider.sv
  - aluIntSqrt.sv
  - aluRetire.sv
  - aluTop.sv
  - target: test
    files:
      - aluTb.sv

// ==== aluDefs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define ALU_DATA_W 32

// Function code width
`define ALU_OP_W 6

// One quotient bit per step
`define ALU_DIV_STEPS 32

// One root bit per step, two radicand bits consumed
`define ALU_SQRT_STEPS 16

`endif

// ==== aluIntDivider.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aluDefs.svh"

module aluIntDivider import aluPkg::*; (
    input  wire logic                   i_reset,
    input  wire logic                   i_clock,
    input  wire logic                   i_start,
    input  wire logic [`ALU_DATA_W-1:0] i_dividend,
    input  wire logic [`ALU_DATA_W-1:0] i_divisor,
    input  wire logic                   i_wantRem,
    output logic                        o_done,
    output aluResT                      o_res
);

    localparam int W    = `ALU_DATA_W;
    localparam int CntW = $clog2(`ALU_DIV_STEPS + 1);

    logic            running;
    logic [CntW-1:0] count;
    logic [W-1:0]    remReg;
    logic [W-1:0]    quoReg;    // Dividend bits out, quotient bits in
    logic [W-1:0]    divReg;
    logic            negQ;
    logic            negR;
    logic            divZero;
    logic            wantRem;
    logic [W:0]      shifted;
    logic [W:0]      trial;
    logic [W-1:0]    remNext;
    logic [W-1:0]    quoNext;
    logic [W-1:0]    quoFinal;
    logic [W-1:0]    remFinal;

    // One restoring step
    always_comb begin
        shifted = {remReg, quoReg[W-1]};
        trial   = shifted - {1'b0, divReg};
        if (trial[W]) begin
            remNext = shifted[W-1:0];
            quoNext = {quoReg[W-2:0], 1'b0};
        end else begin
            remNext = trial[W-1:0];
            quoNext = {quoReg[W-2:0], 1'b1};
        end
        // Min over -1 falls out of the magnitude math as 2^31
        quoFinal = divZero ? '1 : (negQ ? -quoNext : quoNext);
        remFinal = negR ? -remNext : remNext;   // Sign of dividend
    end

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            running <= 1'b0;
            count   <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                running <= 1'b1;
                count   <= CntW'(`ALU_DIV_STEPS);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == CntW'(1)) begin
                    running <= 1'b0;
                    o_done  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_reset) begin
        if (i_start) begin
            remReg  <= '0;
            quoReg  <= i_dividend[W-1] ? -i_dividend : i_dividend;
            divReg  <= i_divisor[W-1] ? -i_divisor : i_divisor;
            negQ    <= i_dividend[W-1] ^ i_divisor[W-1];
            negR    <= i_dividend[W-1];
            divZero <= (i_divisor == '0);
            wantRem <= i_wantRem;
        end else if (running) begin
            remReg <= remNext;
            quoReg <= quoNext;
            if (count == CntW'(1)) begin
                o_res.data <= wantRem ? remFinal : quoFinal;
                o_res.err  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aluIntSqrt.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aluDefs.svh"

module aluIntSqrt import aluPkg::*; (
    input  wire logic                   i_reset,
    input  wire logic                   i_clock,
    input  wire logic                   i_start,
    input  wire logic [`ALU_DATA_W-1:0] i_radicand,
    output logic                        o_done,
    output aluResT                      o_res
);

    localparam int W    = `ALU_DATA_W;
    localparam int RtW  = W / 2;
    localparam int CntW = $clog2(`ALU_SQRT_STEPS + 1);

    logic            running;
    logic [CntW-1:0] count;
    logic [W-1:0]    radReg;
    logic [RtW:0]    remReg;    // Never above 2*root
    logic [RtW-1:0]  rootReg;
    logic [RtW+2:0]  shifted;
    logic [RtW+3:0]  trial;
    logic [RtW:0]    remNext;
    logic [RtW-1:0]  rootNext;

    always_comb begin
        shifted = {remReg, radReg[W-1:W-2]};
        trial   = {1'b0, shifted} - {2'b00, rootReg, 2'b01};
        if (trial[RtW+3]) begin
            remNext  = shifted[RtW:0];
            rootNext = {rootReg[RtW-2:0], 1'b0};
        end else begin
            remNext  = trial[RtW:0];
            rootNext = {rootReg[RtW-2:0], 1'b1};
        end
    end

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            running <= 1'b0;
            count   <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                running <= 1'b1;
                count   <= CntW'(`ALU_SQRT_STEPS);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == CntW'(1)) begin
                    running <= 1'b0;
                    o_done  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_reset) begin
        if (i_start) begin
            radReg  <= i_radicand;
            remReg  <= '0;
            rootReg <= '0;
        end else if (running) begin
            radReg  <= radReg << 2;     // Next bit pair
            remReg  <= remNext;
            rootReg <= rootNext;
            if (count == CntW'(1)) begin
                o_res.data <= W'(rootNext);
                o_res.err  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aluIssue.sv ====
`default_nettype none
`timescale 1ns/1ps

module aluIssue import aluPkg::*; (
    input  wire logic     i_reset,
    input  wire logic     i_clock,
    input  wire logic     i_reqValid,
    input  wire aluReqT   i_req,
    output logic          o_reqReady,
    output logic          o_issValid,
    output aluIssueT      o_iss,
    input  wire logic     i_simpleReady,
    input  wire logic     i_simpleBusy,
    input  wire logic     i_iterDone
);

    logic held;     // Issue register holds an item
    logic busy;     // Iterative op running
    logic iterItem;
    logic take;

    function automatic aluUnitE decodeUnit(input aluOpE op);
        case (op)
            opAdd, opSub, opMul, opSla, opSra,
            opEq, opNe, opGt, opLt, opGtu, opLtu,
            opNot, opAnd, opOr, opXor, opXnor,
            opSll, opSrl:   return unitSimple;
            opDiv, opMod:   return unitDiv;
            opIsqrt:        return unitSqrt;
            default:        return unitIllegal;
        endcase
    endfunction

    assign iterItem = (o_iss.unit == unitDiv) || (o_iss.unit == unitSqrt);

    // Iterative items wait until the simple path is empty
    assign o_issValid = held && (!iterItem || !i_simpleBusy);
    assign take       = o_issValid && (iterItem || i_simpleReady);

    // No new request in the cycle an iterative op starts
    assign o_reqReady = !busy && (!held || (take && !iterItem));

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            held <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (o_reqReady && i_reqValid) begin
                held <= 1'b1;
            end else if (take) begin
                held <= 1'b0;
            end
            if (take && iterItem) begin
                busy <= 1'b1;
            end else if (i_iterDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_reset) begin
        if (o_reqReady && i_reqValid) begin
            o_iss.op   <= i_req.op;
            o_iss.a    <= i_req.a;
            o_iss.b    <= i_req.b;
            o_iss.unit <= decodeUnit(i_req.op);
        end
    end

endmodule

`default_nettype wire

// ==== aluPkg.sv ====
`default_nettype none

`include "aluDefs.svh"

package aluPkg;

    // Function codes, float codes left out
    typedef enum logic [`ALU_OP_W-1:0] {
        opAdd   = 6'h00,
        opSub   = 6'h01,
        opMul   = 6'h02,
        opIsqrt = 6'h03,
        opDiv   = 6'h04,
        opMod   = 6'h05,
        opSla   = 6'h06,
        opSra   = 6'h07,
        opEq    = 6'h08,
        opNe    = 6'h09,
        opGt    = 6'h0a,
        opLt    = 6'h0b,
        opGtu   = 6'h0c,
        opLtu   = 6'h0d,
        opNot   = 6'h10,
        opAnd   = 6'h11,
        opOr    = 6'h12,
        opXor   = 6'h13,
        opXnor  = 6'h14,
        opSll   = 6'h16,
        opSrl   = 6'h17
    } aluOpE;

    typedef enum logic [1:0] {
        unitSimple  = 2'd0,
        unitDiv     = 2'd1,
        unitSqrt    = 2'd2,
        unitIllegal = 2'd3
    } aluUnitE;

    typedef struct packed {
        aluOpE                  op;
        logic [`ALU_DATA_W-1:0] a;
        logic [`ALU_DATA_W-1:0] b;
    } aluReqT;

    // Request after decode
    typedef struct packed {
        aluOpE                  op;
        logic [`ALU_DATA_W-1:0] a;
        logic [`ALU_DATA_W-1:0] b;
        aluUnitE                unit;
    } aluIssueT;

    typedef struct packed {
        logic [`ALU_DATA_W-1:0] data;
        logic                   err;
    } aluResT;

endpackage

`default_nettype wire

// ==== aluRetire.sv ====
`default_nettype none
`timescale 1ns/1ps

module aluRetire import aluPkg::*; (
    input  wire logic   i_reset,
    input  wire logic   i_clock,
    input  wire logic   i_simpleValid,
    input  wire aluResT i_simpleRes,
    output logic        o_simpleReady,
    input  wire logic   i_divDone,
    input  wire aluResT i_divRes,
    input  wire logic   i_sqrtDone,
    input  wire aluResT i_sqrtRes,
    output logic        o_resValid,
    output aluResT      o_res,
    input  wire logic   i_resReady
);

    logic full;
    logic load;

    // Empty or drained this cycle
    assign o_simpleReady = !full || i_resReady;

    // Iterative units only finish into an empty register
    assign load = (i_simpleValid && o_simpleReady) || i_divDone || i_sqrtDone;

    assign o_resValid = full;

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (i_resReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge i_reset) begin
        if (load) begin
            if (i_divDone) begin
                o_res <= i_divRes;
            end else if (i_sqrtDone) begin
                o_res <= i_sqrtRes;
            end else begin
                o_res <= i_simpleRes;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aluSimpleExec.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aluDefs.svh"

module aluSimpleExec import aluPkg::*; (
    input  wire logic     i_reset,
    input  wire logic     i_clock,
    input  wire logic     i_issValid,
    input  wire aluIssueT i_iss,
    output logic          o_issReady,
    output logic          o_valid,
    output aluResT        o_res,
    input  wire logic     i_ready,
    output logic          o_busy
);

    localparam int ShW = $clog2(`ALU_DATA_W);

    logic                   isSimple;
    logic                   load;
    logic [ShW-1:0]         shamt;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    aluResT                 resNext;

    assign isSimple   = (i_iss.unit == unitSimple) || (i_iss.unit == unitIllegal);
    assign o_issReady = !o_valid || i_ready;
    assign load       = i_issValid && isSimple && o_issReady;

    // Item here or retire register still full
    assign o_busy = o_valid || !i_ready;

    assign a     = i_iss.a;
    assign b     = i_iss.b;
    assign shamt = i_iss.b[ShW-1:0];    // Low 5 bits only

    always_comb begin
        resNext = '0;
        if (i_iss.unit == unitIllegal) begin
            resNext.err = 1'b1;
        end else begin
            case (i_iss.op)
                opAdd:   resNext.data = a + b;
                opSub:   resNext.data = a - b;
                opMul:   resNext.data = a * b;      // Low word kept
                opSla:   resNext.data = a << shamt;
                opSra:   resNext.data = $signed(a) >>> shamt;
                opEq:    resNext.data = `ALU_DATA_W'(a == b);
                opNe:    resNext.data = `ALU_DATA_W'(a != b);
                opGt:    resNext.data = `ALU_DATA_W'($signed(a) > $signed(b));
                opLt:    resNext.data = `ALU_DATA_W'($signed(a) < $signed(b));
                opGtu:   resNext.data = `ALU_DATA_W'(a > b);
                opLtu:   resNext.data = `ALU_DATA_W'(a < b);
                opNot:   resNext.data = ~a;
                opAnd:   resNext.data = a & b;
                opOr:    resNext.data = a | b;
                opXor:   resNext.data = a ^ b;
                opXnor:  resNext.data = a ~^ b;
                opSll:   resNext.data = a << shamt;
                opSrl:   resNext.data = a >> shamt;
                default: resNext.err  = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_reset or posedge i_clock) begin
        if (i_clock) begin
            o_valid <= 1'b0;
        end else if (o_issReady) begin
            o_valid <= i_issValid && isSimple;
        end
    end

    always_ff @(posedge i_reset) begin
        if (load) begin
            o_res <= resNext;
        end
    end

endmodule

`default_nettype wire

// ==== aluTbTable.svh ====
`ifndef ALU_TB_TABLE_SVH
`define ALU_TB_TABLE_SVH

// Columns are op, a, b, expected data, expected err
task automatic loadTable();
    // Single-cycle ops back to back
    addEntry(opAdd,  32'h00000005, 32'h00000003, 32'h00000008, 1'b0);
    addEntry(opAdd,  32'hffffffff, 32'h00000002, 32'h00000001, 1'b0);
    addEntry(opSub,  32'h00000003, 32'h00000005, 32'hfffffffe, 1'b0);
    addEntry(opMul,  32'h00010001, 32'h00010001, 32'h00020001, 1'b0);
    addEntry(opMul,  32'hfffffffe, 32'h00000003, 32'hfffffffa, 1'b0);
    addEntry(opSla,  32'h00000001, 32'h00000024, 32'h00000010, 1'b0);
    addEntry(opSra,  32'h80000000, 32'h00000004, 32'hf8000000, 1'b0);
    addEntry(opEq,   32'h00000005, 32'h00000005, 32'h00000001, 1'b0);
    addEntry(opNe,   32'h00000005, 32'h00000005, 32'h00000000, 1'b0);
    addEntry(opGt,   32'h00000001, 32'hffffffff, 32'h00000001, 1'b0);
    addEntry(opLt,   32'h00000001, 32'hffffffff, 32'h00000000, 1'b0);
    addEntry(opGtu,  32'h00000001, 32'hffffffff, 32'h00000000, 1'b0);
    addEntry(opLtu,  32'h00000001, 32'hffffffff, 32'h00000001, 1'b0);
    addEntry(opNot,  32'h0f0f0f0f, 32'h00000000, 32'hf0f0f0f0, 1'b0);
    addEntry(opAnd,  32'hff00ff00, 32'h0ff00ff0, 32'h0f000f00, 1'b0);
    addEntry(opOr,   32'hff00ff00, 32'h0ff00ff0, 32'hfff0fff0, 1'b0);
    addEntry(opXor,  32'hff00ff00, 32'h0ff00ff0, 32'hf0f0f0f0, 1'b0);
    addEntry(opXnor, 32'hff00ff00, 32'h0ff00ff0, 32'h0f0f0f0f, 1'b0);
    addEntry(opSll,  32'h12345678, 32'h00000008, 32'h34567800, 1'b0);
    addEntry(opSrl,  32'h80000000, 32'h0000001f, 32'h00000001, 1'b0);
    addEntry(opSrl,  32'hf0000000, 32'h00000021, 32'h78000000, 1'b0);
    // Signed division, zero divisor, overflow
    addEntry(opDiv,  32'h00000007, 32'h00000002, 32'h00000003, 1'b0);
    addEntry(opDiv,  32'hfffffff9, 32'h00000002, 32'hfffffffd, 1'b0);
    addEntry(opMod,  32'hfffffff9, 32'h00000002, 32'hffffffff, 1'b0);
    addEntry(opMod,  32'h00000007, 32'hfffffffe, 32'h00000001, 1'b0);
    addEntry(opDiv,  32'h00000007, 32'hfffffffe, 32'hfffffffd, 1'b0);
    addEntry(opDiv,  32'hfffffff9, 32'hfffffffe, 32'h00000003, 1'b0);
    addEntry(opDiv,  32'h12345678, 32'h00000000, 32'hffffffff, 1'b0);
    addEntry(opMod,  32'h12345678, 32'h00000000, 32'h12345678, 1'b0);
    addEntry(opMod,  32'hfffffffb, 32'h00000000, 32'hfffffffb, 1'b0);
    addEntry(opDiv,  32'h80000000, 32'hffffffff, 32'h80000000, 1'b0);
    addEntry(opMod,  32'h80000000, 32'hffffffff, 32'h00000000, 1'b0);
    addEntry(opAdd,  32'h00000001, 32'h00000001, 32'h00000002, 1'b0);  // Must follow the mod
    // Square root
    addEntry(opIsqrt, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0);
    addEntry(opIsqrt, 32'h00000001, 32'h00000000, 32'h00000001, 1'b0);
    addEntry(opIsqrt, 32'h00000090, 32'h00000000, 32'h0000000c, 1'b0);
    addEntry(opIsqrt, 32'h0000000f, 32'h00000000, 32'h00000003, 1'b0);
    addEntry(opIsqrt, 32'h40000000, 32'h00000000, 32'h00008000, 1'b0);
    addEntry(opIsqrt, 32'hffffffff, 32'h00000000, 32'h0000ffff, 1'b0);
    // Float and unlisted codes
    addEntry(aluOpE'(6'h20), 32'h12345678, 32'h00000001, 32'h00000000, 1'b1);
    addEntry(aluOpE'(6'h0e), 32'h00000003, 32'h00000004, 32'h00000000, 1'b1);
    addEntry(aluOpE'(6'h15), 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b1);
    addEntry(aluOpE'(6'h3f), 32'h00000000, 32'h00000000, 32'h00000000, 1'b1);
endtask

`endif

// ==== aluTb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aluDefs.svh"

module aluTb import aluPkg::*; ();

    localparam int ReqTimeout = 200;
    localparam int ResTimeout = 200;
    localparam int NumRandom  = 48;

    logic   clock;
    logic   reset;
    logic   reqValid;
    aluReqT req;
    logic   reqReady;
    logic   resValid;
    aluResT res;
    logic   resReady;

    aluReqT reqQ[$];
    aluResT expQ[$];
    logic [31:0] rngState;
    logic        readyLevel;
    int          readyStretch;
    logic        abortRun;
    int dataErrors;
    int errErrors;
    int protocolErrors;
    int timeouts;

    // Clock enters on i_reset, reset on i_clock
    aluTop DUT (
        .i_reset    (clock),
        .i_clock    (reset),
        .i_reqValid (reqValid),
        .i_req      (req),
        .o_reqReady (reqReady),
        .o_resValid (resValid),
        .o_res      (res),
        .i_resReady (resReady)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic drawRandom(output logic [31:0] r);
        rngState = xorshift32(rngState);
        r = rngState;
    endtask

    // Largest root whose square fits, one bit at a time from the top
    function automatic logic [31:0] floorSqrt(input logic [31:0] x);
        logic [15:0] root;
        logic [15:0] trialRoot;
        logic [63:0] square;
        root = '0;
        for (int bitIdx = 15; bitIdx >= 0; bitIdx--) begin
            trialRoot = root | (16'h1 << bitIdx);
            square    = 64'(trialRoot) * 64'(trialRoot);
            if (square <= 64'(x)) begin
                root = trialRoot;
            end
        end
        return 32'(root);
    endfunction

    function automatic aluResT modelResult(input aluReqT r);
        aluResT                        m;
        logic signed [`ALU_DATA_W-1:0] sa;
        logic signed [`ALU_DATA_W-1:0] sb;
        logic signed [`ALU_DATA_W-1:0] quo;
        logic signed [`ALU_DATA_W-1:0] rem;
        logic                          overflow;
        m        = '0;
        sa       = r.a;
        sb       = r.b;
        overflow = (r.a == 32'h80000000) && (r.b == 32'hffffffff);
        // Signed quotient and remainder, zero divisor and overflow by rule
        if (r.b == 0) begin
            quo = '1;
            rem = sa;
        end else if (overflow) begin
            quo = sa;
            rem = '0;
        end else begin
            quo = sa / sb;
            rem = sa % sb;
        end
        case (r.op)
            opAdd:   m.data = r.a + r.b;
            opSub:   m.data = r.a - r.b;
            opMul:   m.data = r.a * r.b;
            opSla,
            opSll:   m.data = r.a << r.b[4:0];
            opSra:   m.data = sa >>> r.b[4:0];
            opSrl:   m.data = r.a >> r.b[4:0];
            opEq:    m.data = {31'b0, r.a == r.b};
            opNe:    m.data = {31'b0, r.a != r.b};
            opGt:    m.data = {31'b0, sa > sb};
            opLt:    m.data = {31'b0, sa < sb};
            opGtu:   m.data = {31'b0, r.a > r.b};
            opLtu:   m.data = {31'b0, r.a < r.b};
            opNot:   m.data = ~r.a;
            opAnd:   m.data = r.a & r.b;
            opOr:    m.data = r.a | r.b;
            opXor:   m.data = r.a ^ r.b;
            opXnor:  m.data = ~(r.a ^ r.b);
            opIsqrt: m.data = floorSqrt(r.a);
            opDiv:   m.data = quo;
            opMod:   m.data = rem;
            default: m.err  = 1'b1;
        endcase
        return m;
    endfunction

    task automatic addEntry(input aluOpE op, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expData, input logic expErr);
        aluReqT r;
        aluResT e;
        r.op   = op;
        r.a    = a;
        r.b    = b;
        e.data = expData;
        e.err  = expErr;
        reqQ.push_back(r);
        expQ.push_back(e);
    endtask

    `include "aluTbTable.svh"

    task automatic addRandomOps(input int count);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        aluReqT      item;
        for (int k = 0; k < count; k++) begin
            drawRandom(r);
            drawRandom(a);
            drawRandom(b);
            if (r[6:5] == 2'b00) begin
                item.op = r[7] ? opIsqrt : (r[8] ? opMod : opDiv);
            end else begin
                item.op = aluOpE'({1'b0, r[4:0]});     // Unlisted codes too
            end
            if (r[9]) begin
                b = b >> r[14:10];  // Small divisors
            end
            item.a = a;
            item.b = b;
            reqQ.push_back(item);
            expQ.push_back(modelResult(item));
        end
    endtask

    task automatic compareData(input aluResT act, input aluResT exp, input int idx);
        if (act.data !== exp.data) begin
            $display("FAIL o_res.data result %0d: expected %h, actual %h",
                     idx, exp.data, act.data);
            dataErrors++;
        end
    endtask

    task automatic compareErr(input aluResT act, input aluResT exp, input int idx);
        if (act.err !== exp.err) begin
            $display("FAIL o_res.err result %0d: expected %h, actual %h",
                     idx, exp.err, act.err);
            errErrors++;
        end
    endtask

    // Random stretches of consumer stall
    task automatic updateReady();
        logic [31:0] r;
        if (readyStretch == 0) begin
            drawRandom(r);
            readyLevel   = (r[3:0] > 4'd5);
            readyStretch = int'(r[7:4] % 6) + 1;
        end
        readyStretch--;
        resReady = readyLevel;
    endtask

    task automatic sendRequests();
        int waitCycles;
        for (int i = 0; i < reqQ.size() && !abortRun; i++) begin
            @(posedge clock);
            #1;
            reqValid   = 1'b1;
            req        = reqQ[i];
            waitCycles = 0;
            @(negedge clock);
            while (!reqReady && !abortRun) begin
                waitCycles++;
                if (waitCycles > ReqTimeout) begin
                    $display("Timeout: request %0d was never accepted", i);
                    timeouts++;
                    abortRun = 1'b1;
                end
                @(negedge clock);
            end
        end
        @(posedge clock);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic receiveResults();
        int     got;
        int     idle;
        logic   holding;
        aluResT heldRes;
        got     = 0;
        idle    = 0;
        holding = 1'b0;
        while (got < expQ.size() && !abortRun) begin
            @(negedge clock);
            if (resValid) begin
                idle = 0;
                if (holding && res !== heldRes) begin
                    $display("Result %0d changed while the consumer was stalled", got);
                    protocolErrors++;
                end
                if (resReady) begin
                    compareData(res, expQ[got], got);
                    compareErr(res, expQ[got], got);
                    got++;
                    holding = 1'b0;
                end else begin
                    holding = 1'b1;
                    heldRes = res;
                end
            end else begin
                if (holding) begin
                    $display("Result %0d was withdrawn before it was taken", got);
                    protocolErrors++;
                    holding = 1'b0;
                end
                idle++;
                if (idle > ResTimeout) begin
                    $display("Timeout: result %0d never arrived", got);
                    timeouts++;
                    abortRun = 1'b1;
                end
            end
            @(posedge clock);
            #1;
            updateReady();
        end
    endtask

    // Nothing may follow the last expected result
    task automatic checkNoExtra();
        @(posedge clock);
        #1;
        resReady = 1'b1;
        repeat (2 * `ALU_DIV_STEPS) begin
            @(negedge clock);
            if (resValid) begin
                $display("Unexpected extra result with data %h", res.data);
                protocolErrors++;
            end
        end
    endtask

    initial begin
        reset          = 1'b1;
        reqValid       = 1'b0;
        req            = '0;
        resReady       = 1'b1;
        rngState       = 32'hd5a8;
        readyLevel     = 1'b1;
        readyStretch   = 0;
        abortRun       = 1'b0;
        dataErrors     = 0;
        errErrors      = 0;
        protocolErrors = 0;
        timeouts       = 0;
        loadTable();
        addRandomOps(NumRandom);
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        fork
            sendRequests();
            receiveResults();
        join
        checkNoExtra();
        $display("Errors: data %0d, err flag %0d, protocol %0d, timeouts %0d",
                 dataErrors, errErrors, protocolErrors, timeouts);
        if (dataErrors + errErrors + protocolErrors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aluTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module aluTop import aluPkg::*; (
    input  wire logic   i_reset,
    input  wire logic   i_clock,
    input  wire logic   i_reqValid,
    input  wire aluReqT i_req,
    output logic        o_reqReady,
    output logic        o_resValid,
    output aluResT      o_res,
    input  wire logic   i_resReady
);

    aluIssueT iss;
    logic     issValid;
    logic     simpleIssReady;
    logic     simpleBusy;
    logic     simpleValid;
    logic     simpleRetReady;
    logic     divStart;
    logic     divDone;
    logic     sqrtStart;
    logic     sqrtDone;
    logic     iterDone;
    aluResT   simpleRes;
    aluResT   divRes;
    aluResT   sqrtRes;

    // issValid is a single cycle for iterative items
    assign divStart  = issValid && (iss.unit == unitDiv);
    assign sqrtStart = issValid && (iss.unit == unitSqrt);
    assign iterDone  = divDone || sqrtDone;

    aluIssue uIssue (
        .i_reset       (i_reset),
        .i_clock       (i_clock),
        .i_reqValid    (i_reqValid),
        .i_req         (i_req),
        .o_reqReady    (o_reqReady),
        .o_issValid    (issValid),
        .o_iss         (iss),
        .i_simpleReady (simpleIssReady),
        .i_simpleBusy  (simpleBusy),
        .i_iterDone    (iterDone)
    );

    aluSimpleExec uSimple (
        .i_reset    (i_reset),
        .i_clock    (i_clock),
        .i_issValid (issValid),
        .i_iss      (iss),
        .o_issReady (simpleIssReady),
        .o_valid    (simpleValid),
        .o_res      (simpleRes),
        .i_ready    (simpleRetReady),
        .o_busy     (simpleBusy)
    );

    aluIntDivider uDivider (
        .i_reset    (i_reset),
        .i_clock    (i_clock),
        .i_start    (divStart),
        .i_dividend (iss.a),
        .i_divisor  (iss.b),
        .i_wantRem  (iss.op == opMod),
        .o_done     (divDone),
        .o_res      (divRes)
    );

    aluIntSqrt uSqrt (
        .i_reset    (i_reset),
        .i_clock    (i_clock),
        .i_start    (sqrtStart),
        .i_radicand (iss.a),
        .o_done     (sqrtDone),
        .o_res      (sqrtRes)
    );

    aluRetire uRetire (
        .i_reset       (i_reset),
        .i_clock       (i_clock),
        .i_simpleValid (simpleValid),
        .i_simpleRes   (simpleRes),
        .o_simpleReady (simpleRetReady),
        .i_divDone     (divDone),
        .i_divRes      (divRes),
        .i_sqrtDone    (sqrtDone),
        .i_sqrtRes     (sqrtRes),
        .o_resValid    (o_resValid),
        .o_res         (o_res),
        .i_resReady    (i_resReady)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
aluPkg.sv
aluIssue.sv
aluSimpleExec.sv
aluIntDivider.sv
aluIntSqrt.sv
aluRetire.sv
aluTop.sv
aluTb.sv
